// File: rtl/axi_defines.svh
`ifndef AXI_DEFINES_SVH
`define AXI_DEFINES_SVH

// Bus widths
`define AXI_ADDR_BITS 32
`define AXI_DATA_BITS 32
`define AXI_STRB_BITS 4
`define AXI_ID_BITS   4

// Burst length field, beats minus one
`define AXI_LEN_BITS  4

// Two-bit slave select field starts here
`define AXI_SEL_LSB   16

`endif

// File: rtl/axi_pkg.sv
`include "axi_defines.svh"

package axi_pkg;

  typedef logic [`AXI_ADDR_BITS-1:0] addr_t;
  typedef logic [`AXI_DATA_BITS-1:0] data_t;
  typedef logic [`AXI_STRB_BITS-1:0] strb_t;
  typedef logic [`AXI_ID_BITS-1:0]   id_t;
  typedef logic [`AXI_LEN_BITS-1:0]  len_t;
  typedef logic [1:0]                resp_t;

  // Target slave of the write in flight
  typedef enum logic [1:0] {ROUTE_S0, ROUTE_S1, ROUTE_S2, ROUTE_NONE} route_t;

  typedef enum logic {W_FREE, W_BUSY} w_lock_t;

  typedef enum logic {AW_IDLE, AW_OUTSTANDING} aw_lock_t;

endpackage

// File: rtl/aw_router.sv
`timescale 1ns/1ps
`include "axi_defines.svh"

module aw_router (
  input  logic            clk,
  input  logic            rstn,
  // Master
  input  axi_pkg::addr_t  awaddr_m,
  input  axi_pkg::id_t    awid_m,
  input  axi_pkg::len_t   awlen_m,
  input  logic            awvalid_m,
  output logic            awready_m,
  // Slave 0
  output axi_pkg::addr_t  awaddr_s0,
  output axi_pkg::id_t    awid_s0,
  output axi_pkg::len_t   awlen_s0,
  output logic            awvalid_s0,
  input  logic            awready_s0,
  // Slave 1
  output axi_pkg::addr_t  awaddr_s1,
  output axi_pkg::id_t    awid_s1,
  output axi_pkg::len_t   awlen_s1,
  output logic            awvalid_s1,
  input  logic            awready_s1,
  // Slave 2
  output axi_pkg::addr_t  awaddr_s2,
  output axi_pkg::id_t    awid_s2,
  output axi_pkg::len_t   awlen_s2,
  output logic            awvalid_s2,
  input  logic            awready_s2,
  // To and from the response side
  output axi_pkg::route_t route,
  input  logic            b_done
);

  import axi_pkg::*;

  aw_lock_t   aw_state, aw_state_next;
  route_t     route_dec;
  route_t     route_q;
  logic [1:0] sel;
  logic       aw_open;
  logic       awready_sel;
  logic       aw_fire;

  // Address map, select values 2 and 3 both land on S2
  assign sel = awaddr_m[`AXI_SEL_LSB +: 2];

  always_comb begin
    case (sel)
      2'd0:    route_dec = ROUTE_S0;
      2'd1:    route_dec = ROUTE_S1;
      default: route_dec = ROUTE_S2;
    endcase
  end

  always_comb begin
    case (route_dec)
      ROUTE_S0: awready_sel = awready_s0;
      ROUTE_S1: awready_sel = awready_s1;
      ROUTE_S2: awready_sel = awready_s2;
      default:  awready_sel = 1'b0;
    endcase
  end

  assign aw_open = (aw_state == AW_IDLE);

  assign awvalid_s0 = aw_open && awvalid_m && (route_dec == ROUTE_S0);
  assign awvalid_s1 = aw_open && awvalid_m && (route_dec == ROUTE_S1);
  assign awvalid_s2 = aw_open && awvalid_m && (route_dec == ROUTE_S2);
  assign awready_m  = aw_open && awvalid_m && awready_sel;
  assign aw_fire    = awvalid_m && awready_m;

  // Payload goes to every slave, only awvalid is steered
  assign awaddr_s0 = awaddr_m;
  assign awaddr_s1 = awaddr_m;
  assign awaddr_s2 = awaddr_m;
  assign awid_s0   = awid_m;
  assign awid_s1   = awid_m;
  assign awid_s2   = awid_m;
  assign awlen_s0  = awlen_m;
  assign awlen_s1  = awlen_m;
  assign awlen_s2  = awlen_m;

  always_comb begin
    case (aw_state)
      AW_IDLE:        aw_state_next = aw_fire ? AW_OUTSTANDING : AW_IDLE;
      AW_OUTSTANDING: aw_state_next = b_done ? AW_IDLE : AW_OUTSTANDING;
      default:        aw_state_next = AW_IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      aw_state <= AW_IDLE;
      route_q  <= ROUTE_NONE;
    end else begin
      aw_state <= aw_state_next;
      if (aw_fire) begin
        route_q <= route_dec;
      end else if (b_done) begin
        route_q <= ROUTE_NONE;
      end
    end
  end

  assign route = route_q;

endmodule

// File: rtl/w_router.sv
`timescale 1ns/1ps

module w_router (
  input  logic           clk,
  input  logic           rstn,
  // Master
  input  axi_pkg::data_t wdata_m,
  input  axi_pkg::strb_t wstrb_m,
  input  logic           wlast_m,
  input  logic           wvalid_m,
  output logic           wready_m,
  // Slave 0
  output axi_pkg::data_t wdata_s0,
  output axi_pkg::strb_t wstrb_s0,
  output logic           wlast_s0,
  output logic           wvalid_s0,
  input  logic           wready_s0,
  input  logic           awvalid_s0,
  input  logic           awready_s0,
  // Slave 1
  output axi_pkg::data_t wdata_s1,
  output axi_pkg::strb_t wstrb_s1,
  output logic           wlast_s1,
  output logic           wvalid_s1,
  input  logic           wready_s1,
  input  logic           awvalid_s1,
  input  logic           awready_s1,
  // Slave 2
  output axi_pkg::data_t wdata_s2,
  output axi_pkg::strb_t wstrb_s2,
  output logic           wlast_s2,
  output logic           wvalid_s2,
  input  logic           wready_s2,
  input  logic           awvalid_s2,
  input  logic           awready_s2
);

  import axi_pkg::*;

  w_lock_t w_state, w_state_next;
  route_t  aw_route;
  route_t  route_q;
  route_t  w_route;
  logic    aw_fire;
  logic    w_last_fire;

  // Only one slave sees awvalid at a time
  always_comb begin
    case ({awvalid_s0, awvalid_s1, awvalid_s2})
      3'b100:  aw_route = ROUTE_S0;
      3'b010:  aw_route = ROUTE_S1;
      3'b001:  aw_route = ROUTE_S2;
      default: aw_route = ROUTE_NONE;
    endcase
  end

  assign aw_fire = (awvalid_s0 && awready_s0) ||
                   (awvalid_s1 && awready_s1) ||
                   (awvalid_s2 && awready_s2);

  assign w_last_fire = wvalid_m && wready_m && wlast_m;

  // Fast path on the AW handshake cycle, latched route afterwards
  assign w_route = (w_state == W_BUSY) ? route_q :
                   aw_fire             ? aw_route : ROUTE_NONE;

  always_comb begin
    case (w_state)
      W_FREE:  w_state_next = (aw_fire && !w_last_fire) ? W_BUSY : W_FREE;
      W_BUSY:  w_state_next = w_last_fire ? W_FREE : W_BUSY;
      default: w_state_next = W_FREE;
    endcase
  end

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      w_state <= W_FREE;
      route_q <= ROUTE_NONE;
    end else begin
      w_state <= w_state_next;
      if (w_state == W_FREE && w_state_next == W_BUSY) begin
        route_q <= aw_route;
      end else if (w_state == W_BUSY && w_state_next == W_FREE) begin
        route_q <= ROUTE_NONE;
      end
    end
  end

  always_comb begin
    wdata_s0  = '0;
    wdata_s1  = '0;
    wdata_s2  = '0;
    wstrb_s0  = '0;
    wstrb_s1  = '0;
    wstrb_s2  = '0;
    wlast_s0  = 1'b0;
    wlast_s1  = 1'b0;
    wlast_s2  = 1'b0;
    wvalid_s0 = 1'b0;
    wvalid_s1 = 1'b0;
    wvalid_s2 = 1'b0;
    wready_m  = 1'b0;
    case (w_route)
      ROUTE_S0: begin
        wdata_s0  = wdata_m;
        wstrb_s0  = wstrb_m;
        wlast_s0  = wlast_m;
        wvalid_s0 = wvalid_m;
        wready_m  = wready_s0;
      end
      ROUTE_S1: begin
        wdata_s1  = wdata_m;
        wstrb_s1  = wstrb_m;
        wlast_s1  = wlast_m;
        wvalid_s1 = wvalid_m;
        wready_m  = wready_s1;
      end
      ROUTE_S2: begin
        wdata_s2  = wdata_m;
        wstrb_s2  = wstrb_m;
        wlast_s2  = wlast_m;
        wvalid_s2 = wvalid_m;
        wready_m  = wready_s2;
      end
      default: ;
    endcase
  end

endmodule

// File: rtl/b_router.sv
`timescale 1ns/1ps

module b_router (
  input  logic            clk,
  input  logic            rstn,
  input  axi_pkg::route_t route,
  // Master
  output axi_pkg::id_t    bid_m,
  output axi_pkg::resp_t  bresp_m,
  output logic            bvalid_m,
  input  logic            bready_m,
  // Slave 0
  input  axi_pkg::id_t    bid_s0,
  input  axi_pkg::resp_t  bresp_s0,
  input  logic            bvalid_s0,
  output logic            bready_s0,
  // Slave 1
  input  axi_pkg::id_t    bid_s1,
  input  axi_pkg::resp_t  bresp_s1,
  input  logic            bvalid_s1,
  output logic            bready_s1,
  // Slave 2
  input  axi_pkg::id_t    bid_s2,
  input  axi_pkg::resp_t  bresp_s2,
  input  logic            bvalid_s2,
  output logic            bready_s2,
  // Write finished
  output logic            b_done
);

  import axi_pkg::*;

  id_t   bid_sel;
  resp_t bresp_sel;
  logic  bvalid_sel;
  logic  resp_mask;

  always_comb begin
    bid_sel    = '0;
    bresp_sel  = '0;
    bvalid_sel = 1'b0;
    case (route)
      ROUTE_S0: begin
        bid_sel    = bid_s0;
        bresp_sel  = bresp_s0;
        bvalid_sel = bvalid_s0;
      end
      ROUTE_S1: begin
        bid_sel    = bid_s1;
        bresp_sel  = bresp_s1;
        bvalid_sel = bvalid_s1;
      end
      ROUTE_S2: begin
        bid_sel    = bid_s2;
        bresp_sel  = bresp_s2;
        bvalid_sel = bvalid_s2;
      end
      default: ;
    endcase
  end

  assign bid_m    = bid_sel;
  assign bresp_m  = bresp_sel;
  assign bvalid_m = bvalid_sel && !resp_mask;
  assign b_done   = bvalid_m && bready_m;

  assign bready_s0 = (route == ROUTE_S0) && bready_m && !resp_mask;
  assign bready_s1 = (route == ROUTE_S1) && bready_m && !resp_mask;
  assign bready_s2 = (route == ROUTE_S2) && bready_m && !resp_mask;

  // Blank the cycle right after a response, until the lock clears
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      resp_mask <= 1'b0;
    end else begin
      resp_mask <= b_done;
    end
  end

endmodule

// File: rtl/axi_write_xbar.sv
`timescale 1ns/1ps

module axi_write_xbar (
  input  logic           clk,
  input  logic           rstn,
  // Master AW
  input  axi_pkg::addr_t awaddr_m,
  input  axi_pkg::id_t   awid_m,
  input  axi_pkg::len_t  awlen_m,
  input  logic           awvalid_m,
  output logic           awready_m,
  // Master W
  input  axi_pkg::data_t wdata_m,
  input  axi_pkg::strb_t wstrb_m,
  input  logic           wlast_m,
  input  logic           wvalid_m,
  output logic           wready_m,
  // Master B
  output axi_pkg::id_t   bid_m,
  output axi_pkg::resp_t bresp_m,
  output logic           bvalid_m,
  input  logic           bready_m,
  // Slave 0
  output axi_pkg::addr_t awaddr_s0,
  output axi_pkg::id_t   awid_s0,
  output axi_pkg::len_t  awlen_s0,
  output logic           awvalid_s0,
  input  logic           awready_s0,
  output axi_pkg::data_t wdata_s0,
  output axi_pkg::strb_t wstrb_s0,
  output logic           wlast_s0,
  output logic           wvalid_s0,
  input  logic           wready_s0,
  input  axi_pkg::id_t   bid_s0,
  input  axi_pkg::resp_t bresp_s0,
  input  logic           bvalid_s0,
  output logic           bready_s0,
  // Slave 1
  output axi_pkg::addr_t awaddr_s1,
  output axi_pkg::id_t   awid_s1,
  output axi_pkg::len_t  awlen_s1,
  output logic           awvalid_s1,
  input  logic           awready_s1,
  output axi_pkg::data_t wdata_s1,
  output axi_pkg::strb_t wstrb_s1,
  output logic           wlast_s1,
  output logic           wvalid_s1,
  input  logic           wready_s1,
  input  axi_pkg::id_t   bid_s1,
  input  axi_pkg::resp_t bresp_s1,
  input  logic           bvalid_s1,
  output logic           bready_s1,
  // Slave 2
  output axi_pkg::addr_t awaddr_s2,
  output axi_pkg::id_t   awid_s2,
  output axi_pkg::len_t  awlen_s2,
  output logic           awvalid_s2,
  input  logic           awready_s2,
  output axi_pkg::data_t wdata_s2,
  output axi_pkg::strb_t wstrb_s2,
  output logic           wlast_s2,
  output logic           wvalid_s2,
  input  logic           wready_s2,
  input  axi_pkg::id_t   bid_s2,
  input  axi_pkg::resp_t bresp_s2,
  input  logic           bvalid_s2,
  output logic           bready_s2
);

  import axi_pkg::*;

  // Target of the outstanding write, and its completion pulse
  route_t route;
  logic   b_done;

  aw_router u_aw (.*);

  // Reads the slave awvalid and awready wires to find its route
  w_router u_w (.*);

  b_router u_b (.*);

endmodule

// File: verif/xbar_checker.sv
`timescale 1ns/1ps

module xbar_checker #(
  parameter int NUM_TXN = 16
) (
  input  logic           clk,
  input  logic           rstn,
  input  axi_pkg::addr_t awaddr_s0, awaddr_s1, awaddr_s2,
  input  axi_pkg::id_t   awid_s0, awid_s1, awid_s2, bid_m,
  input  axi_pkg::len_t  awlen_s0, awlen_s1, awlen_s2,
  input  axi_pkg::data_t wdata_s0, wdata_s1, wdata_s2,
  input  axi_pkg::strb_t wstrb_s0, wstrb_s1, wstrb_s2,
  input  axi_pkg::resp_t bresp_m,
  input  logic           awvalid_s0, awvalid_s1, awvalid_s2,
  input  logic           wvalid_s0, wvalid_s1, wvalid_s2,
  input  logic           wready_s0, wready_s1, wready_s2,
  input  logic           wlast_s0, wlast_s1, wlast_s2,
  input  logic           bready_s0, bready_s1, bready_s2,
  input  logic           awvalid_m, awready_m, wready_m, bvalid_m, bready_m,
  output int             err_count,
  output int             b_seen
);

  import axi_pkg::*;

  // Eight words per write, same layout as the stim file
  logic [31:0] stim [0:8*NUM_TXN-1];
  logic [2:0]  awv, wv, wr, wl, br;
  logic        busy = 1'b0;
  logic        rst_q = 1'b0;
  int          aw_idx = 0;
  int          w_idx = 0;
  int          beat = 0;
  int          sel;
  addr_t       aw_addr;
  id_t         aw_id;
  len_t        aw_len;
  data_t       w_data;
  strb_t       w_strb;

  initial begin
    err_count = 0;
    b_seen = 0;
    $readmemh("verif/xbar_stim.txt", stim);
  end

  task automatic flag(input string msg);
    err_count++;
    $display("** Error at %0t ns: %s", $time, msg);
  endtask

  always @(posedge clk) begin
    awv = {awvalid_s2, awvalid_s1, awvalid_s0};
    wv  = {wvalid_s2, wvalid_s1, wvalid_s0};
    wr  = {wready_s2, wready_s1, wready_s0};
    wl  = {wlast_s2, wlast_s1, wlast_s0};
    br  = {bready_s2, bready_s1, bready_s0};
    if (!rstn || !rst_q) begin
      if (awv != 3'b0 || wv != 3'b0 || bvalid_m || awready_m || wready_m)
        flag("valid or ready high during or right after reset");
    end
    if (rstn) begin
      if (busy && (awv != 3'b0 || awready_m))
        flag("address passed on while a write is outstanding");
      if (!busy && br != 3'b0)
        flag($sformatf("bready pattern %b with no write outstanding", br));
      if (awv != 3'b0) begin
        sel = (aw_idx < NUM_TXN) ? int'(stim[8*aw_idx+5]) : 0;
        if (aw_idx >= NUM_TXN || awv != (3'b1 << sel)) begin
          flag($sformatf("awvalid pattern %b on the wrong slave", awv));
        end else begin
          case (sel)
            0:       {aw_addr, aw_id, aw_len} = {awaddr_s0, awid_s0, awlen_s0};
            1:       {aw_addr, aw_id, aw_len} = {awaddr_s1, awid_s1, awlen_s1};
            default: {aw_addr, aw_id, aw_len} = {awaddr_s2, awid_s2, awlen_s2};
          endcase
          if (aw_addr != stim[8*aw_idx] || aw_id != stim[8*aw_idx+1][3:0] ||
              aw_len != stim[8*aw_idx+2][3:0])
            flag($sformatf("AW payload %h/%h/%h on slave %0d", aw_addr, aw_id, aw_len, sel));
        end
      end
      if (awvalid_m && awready_m) begin
        busy = 1'b1;
        aw_idx++;
      end
      if (wv != 3'b0) begin
        sel = (w_idx < NUM_TXN) ? int'(stim[8*w_idx+5]) : 0;
        if (w_idx >= NUM_TXN || wv != (3'b1 << sel)) begin
          flag($sformatf("wvalid pattern %b on the wrong slave", wv));
        end else if (wr[sel]) begin
          case (sel)
            0:       {w_data, w_strb} = {wdata_s0, wstrb_s0};
            1:       {w_data, w_strb} = {wdata_s1, wstrb_s1};
            default: {w_data, w_strb} = {wdata_s2, wstrb_s2};
          endcase
          if (w_data != stim[8*w_idx+3] + beat || w_strb != stim[8*w_idx+4][3:0])
            flag($sformatf("beat %0d carries %h/%h", beat, w_data, w_strb));
          if (wl[sel] != (beat == int'(stim[8*w_idx+2][3:0])))
            flag($sformatf("wlast wrong on beat %0d of write %0d", beat, w_idx));
          if (wl[sel]) begin
            w_idx++;
            beat = 0;
          end else begin
            beat++;
          end
        end
      end
      if (bvalid_m && bready_m) begin
        if (b_seen >= aw_idx) begin
          flag("B response with no write outstanding");
        end else begin
          if (bid_m != stim[8*b_seen+1][3:0] || bresp_m != stim[8*b_seen+6][1:0])
            flag($sformatf("B response id %h resp %0d", bid_m, bresp_m));
          sel = int'(stim[8*b_seen+5]);
          if (br != (3'b1 << sel))
            flag($sformatf("bready pattern %b on the wrong slave", br));
        end
        b_seen++;
        busy = 1'b0;
      end
    end
    rst_q = rstn;
  end

endmodule

// File: verif/tb_axi_write_xbar.sv
`timescale 1ns/1ps

// Slave with random ready stalls, answers with the id it received
module slave_model (
  input  logic           clk,
  input  logic           rstn,
  input  logic [3:0]     stall,
  input  axi_pkg::resp_t resp_code,
  input  axi_pkg::id_t   awid,
  input  logic           awvalid, wvalid, wlast, bready,
  output logic           awready, wready, bvalid,
  output axi_pkg::id_t   bid,
  output axi_pkg::resp_t bresp
);

  import axi_pkg::*;

  integer      seed = 48700;
  logic [31:0] rnd;
  logic [3:0]  st_q, st_live;
  logic        got_aw, got_last, b_fire;
  id_t         id_q;
  resp_t       resp_q;

  always @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      got_aw = 1'b0;
      got_last = 1'b0;
      // Ready may sit high in reset, valid may not
      awready = 1'b1;
      wready = 1'b1;
      bvalid = 1'b0;
      bid = '0;
      bresp = '0;
    end else begin
      st_live = stall;
      if (awvalid && awready) begin
        got_aw = 1'b1;
        id_q = awid;
        resp_q = resp_code;
        st_q = stall;
      end
      if (wvalid && wready && wlast)
        got_last = 1'b1;
      b_fire = bvalid && bready;
      rnd = $random(seed);
      #1;
      if (b_fire) begin
        bvalid = 1'b0;
        got_aw = 1'b0;
        got_last = 1'b0;
      end else if (got_aw && got_last && !(st_q[3] && rnd[2])) begin
        bvalid = 1'b1;
      end
      bid = id_q;
      bresp = resp_q;
      awready = !got_aw && !(st_live[0] && rnd[0]);
      // Holding wready low on the AW cycle forces the latched W path
      wready = got_aw ? !(st_q[2] && rnd[1]) : !st_live[1];
    end
  end

endmodule

module tb_axi_write_xbar;

  import axi_pkg::*;

  localparam int NUM_TXN = 16;

  logic        clk, rstn;
  addr_t       awaddr_m, awaddr_s0, awaddr_s1, awaddr_s2;
  id_t         awid_m, awid_s0, awid_s1, awid_s2, bid_m, bid_s0, bid_s1, bid_s2;
  len_t        awlen_m, awlen_s0, awlen_s1, awlen_s2;
  data_t       wdata_m, wdata_s0, wdata_s1, wdata_s2;
  strb_t       wstrb_m, wstrb_s0, wstrb_s1, wstrb_s2;
  resp_t       bresp_m, bresp_s0, bresp_s1, bresp_s2, cur_resp;
  logic        awvalid_m, awready_m, wlast_m, wvalid_m, wready_m, bvalid_m, bready_m;
  logic        awvalid_s0, awvalid_s1, awvalid_s2, awready_s0, awready_s1, awready_s2;
  logic        wvalid_s0, wvalid_s1, wvalid_s2, wready_s0, wready_s1, wready_s2;
  logic        wlast_s0, wlast_s1, wlast_s2, bvalid_s0, bvalid_s1, bvalid_s2;
  logic        bready_s0, bready_s1, bready_s2;
  logic [3:0]  cur_stall;
  logic [31:0] stim [0:8*NUM_TXN-1];
  int          err_count, b_seen;
  string       hung_ch;

  axi_write_xbar UUT (.*);

  xbar_checker #(.NUM_TXN(NUM_TXN)) u_chk (.*);

  slave_model u_s0 (.clk(clk), .rstn(rstn), .stall(cur_stall), .resp_code(cur_resp),
    .awid(awid_s0), .awvalid(awvalid_s0), .wvalid(wvalid_s0), .wlast(wlast_s0),
    .bready(bready_s0), .awready(awready_s0), .wready(wready_s0), .bvalid(bvalid_s0),
    .bid(bid_s0), .bresp(bresp_s0));
  slave_model u_s1 (.clk(clk), .rstn(rstn), .stall(cur_stall), .resp_code(cur_resp),
    .awid(awid_s1), .awvalid(awvalid_s1), .wvalid(wvalid_s1), .wlast(wlast_s1),
    .bready(bready_s1), .awready(awready_s1), .wready(wready_s1), .bvalid(bvalid_s1),
    .bid(bid_s1), .bresp(bresp_s1));
  slave_model u_s2 (.clk(clk), .rstn(rstn), .stall(cur_stall), .resp_code(cur_resp),
    .awid(awid_s2), .awvalid(awvalid_s2), .wvalid(wvalid_s2), .wlast(wlast_s2),
    .bready(bready_s2), .awready(awready_s2), .wready(wready_s2), .bvalid(bvalid_s2),
    .bid(bid_s2), .bresp(bresp_s2));

  always #50 clk = ~clk;

  // Next address goes out right after the last one, while that write is still open
  task automatic drive_aw();
    int t;
    for (int i = 0; i < NUM_TXN && hung_ch == ""; i++) begin
      awaddr_m = stim[8*i];
      awid_m = stim[8*i+1][3:0];
      awlen_m = stim[8*i+2][3:0];
      cur_resp = stim[8*i+6][1:0];
      cur_stall = stim[8*i+7][3:0];
      awvalid_m = 1'b1;
      t = 0;
      @(posedge clk);
      while (!awready_m && t < 200) begin
        @(posedge clk);
        t++;
      end
      if (!awready_m)
        hung_ch = "AW";
      #1;
    end
    awvalid_m = 1'b0;
  endtask

  task automatic drive_w();
    int t;
    int len;
    for (int i = 0; i < NUM_TXN && hung_ch == ""; i++) begin
      len = int'(stim[8*i+2][3:0]);
      for (int b = 0; b <= len && hung_ch == ""; b++) begin
        wdata_m = stim[8*i+3] + b;
        wstrb_m = stim[8*i+4][3:0];
        wlast_m = (b == len);
        wvalid_m = 1'b1;
        t = 0;
        @(posedge clk);
        while (!wready_m && t < 200) begin
          @(posedge clk);
          t++;
        end
        if (!wready_m)
          hung_ch = "W";
        #1;
      end
    end
    wvalid_m = 1'b0;
    wlast_m = 1'b0;
  endtask

  initial begin
    int t;
    int last_seen;
    clk = 1'b0;
    rstn = 1'b1;
    awaddr_m = '0;
    awid_m = '0;
    awlen_m = '0;
    awvalid_m = 1'b0;
    wdata_m = '0;
    wstrb_m = '0;
    wlast_m = 1'b0;
    wvalid_m = 1'b0;
    bready_m = 1'b0;
    cur_resp = '0;
    cur_stall = '0;
    hung_ch = "";
    $readmemh("verif/xbar_stim.txt", stim);
    #10 rstn = 1'b0;
    repeat (5) @(posedge clk);
    #1;
    rstn = 1'b1;
    bready_m = 1'b1;
    // Master stays idle for the first cycle out of reset
    @(posedge clk);
    #1;
    fork
      drive_aw();
      drive_w();
    join_none
    t = 0;
    last_seen = 0;
    while (b_seen < NUM_TXN && t < 200 && hung_ch == "") begin
      @(posedge clk);
      #2;
      t = (b_seen != last_seen) ? 0 : t + 1;
      last_seen = b_seen;
    end
    if (hung_ch == "" && b_seen < NUM_TXN)
      hung_ch = "B";
    if (hung_ch != "")
      $display("Timeout: the %s channel made no progress for 200 cycles", hung_ch);
    else
      repeat (2) @(posedge clk);
    $display("Checks done: %0d errors, %0d of %0d writes answered",
             err_count, b_seen, NUM_TXN);
    if (hung_ch == "" && err_count == 0 && b_seen == NUM_TXN) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

// File: compile.f
+incdir+rtl
rtl/axi_pkg.sv
rtl/aw_router.sv
rtl/w_router.sv
rtl/b_router.sv
rtl/axi_write_xbar.sv
verif/xbar_checker.sv
verif/tb_axi_write_xbar.sv

// File: run.sh
#!/bin/sh
set -e

cd "$(dirname "$0")"

verilator --binary --timing -j 0 -f compile.f --top-module tb_axi_write_xbar -o sim_xbar

./obj_dir/sim_xbar > sim.log
cat sim.log

if grep -q "^sim passed$" sim.log; then
  exit 0
fi
exit 1

// File: verif/xbar_stim.txt
// addr     id len data     strb slave resp stall
// stall bits: 0 AW stalls, 1 W held off on AW cycle, 2 W stalls, 3 B delayed
00001000 1 0 11110000 f 0 0 0
00010040 2 3 22220000 f 1 0 0
00020080 3 7 33330000 3 2 2 2
00030100 4 f 44440000 c 2 0 4
00001200 5 1 55550000 f 0 3 3
00014000 6 2 66660000 1 1 1 5
0002f000 7 0 77770000 f 2 0 2
00008000 8 4 88880000 f 0 2 c
0001c000 9 5 99990000 6 1 0 f
0003fffc a 0 aaaa0000 8 2 1 0
00000004 b f bbbb0000 f 0 0 6
00011110 c 1 cccc0000 f 1 2 2
00022220 d 3 dddd0000 f 2 0 9
00000010 e 0 eeee0000 f 0 1 a
00010020 f 7 ffff0000 f 1 0 0
00033330 0 2 01010000 f 2 3 b
